// File: tb.f
design/sched_pkg.sv
design/sched_pick_if.sv
design/queue_eligibility.sv
design/rr_queue_picker.sv
design/port_slot_table.sv
design/fetch_scheduler_top.sv
testbench/sched_tb.sv

// File: Makefile
# Verilator flow for the fetch scheduler testbench

TOP := sched_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

# The log decides pass or fail
sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/sched_tb.sv
// Self-checking testbench for the egress fetch scheduler
// Random queue traffic, pause bursts and fetch back-pressure, checked each cycle
// against a cycle-level model of rotation, pause, round-robin and slots

`timescale 1ns/1ps

module sched_tb;

    localparam int NP  = sched_pkg::DEF_NUM_PORTS;
    localparam int TC  = sched_pkg::DEF_TC_COUNT;
    localparam int SRC = sched_pkg::DEF_SRC_COUNT;
    localparam int Q   = TC * SRC;
    localparam int PIW = sched_pkg::PORT_IDX_W;

    logic                            clk;
    logic                            rst_n;
    logic [NP-1:0][TC-1:0][SRC-1:0]  queue_valid;
    logic [NP-1:0][TC-1:0]           pfc;
    logic                            fetch_valid;
    logic                            fetch_ready;
    logic [PIW-1:0]                  fetch_port;
    logic [sched_pkg::TC_IDX_W-1:0]  fetch_tc;
    logic [sched_pkg::SRC_IDX_W-1:0] fetch_src;
    logic                            pop_valid;
    logic [PIW-1:0]                  pop_port;
    logic [sched_pkg::TC_IDX_W-1:0]  pop_tc;
    logic [sched_pkg::SRC_IDX_W-1:0] pop_src;

    // Packet count per queue, as the queue manager holds it
    int cnt [NP][Q];
    // Pop seen last cycle, applied to the counts one edge later
    bit dec_pend;
    int dec_port;
    int dec_q;

    // Reference model state
    int                    m_cur;
    logic [NP-1:0][TC-1:0] m_pfc_q;
    int                    m_ptr [NP];
    bit                    m_full [NP];
    int                    m_slot [NP];
    bit                    m_pop_valid;
    int                    m_pop_port;
    int                    m_pop_q;

    // Stimulus knobs
    int add_pct;
    // Pause toggle rate per mille
    // Zero rebuilds pfc from hold_tc alone
    int pfc_pm;
    // 0 random, 1 held low, 2 held high
    int ready_mode;
    int hold_tc;
    int hold_age;
    bit                      stall_seen [NP];
    sched_pkg::sched_entry_t stall_entry [NP];

    int    errors;
    int    checks;
    int    pops;
    int    accepts;
    int    test_errors;
    int    n;
    bit    hung;
    string test_name;

    fetch_scheduler_top #(
        .NUM_PORTS(NP),
        .TC_COUNT (TC),
        .SRC_COUNT(SRC)
    ) i_fetch_scheduler_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .queue_valid(queue_valid),
        .pfc        (pfc),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready),
        .fetch_port (fetch_port),
        .fetch_tc   (fetch_tc),
        .fetch_src  (fetch_src),
        .pop_valid  (pop_valid),
        .pop_port   (pop_port),
        .pop_tc     (pop_tc),
        .pop_src    (pop_src)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Flat queue index to class and source
    function automatic sched_pkg::sched_entry_t to_entry(input int q);
        sched_pkg::sched_entry_t e;
        e.tc  = sched_pkg::TC_IDX_W'(q / SRC);
        e.src = sched_pkg::SRC_IDX_W'(q % SRC);
        return e;
    endfunction

    // Port and queue as shown in mismatch lines
    function automatic string entry_text(input logic [PIW-1:0] port,
                                         input sched_pkg::sched_entry_t e);
        return $sformatf("port %0d tc %0d src %0d", port, e.tc, e.src);
    endfunction

    task automatic check_pop(input string name, input logic [PIW-1:0] exp_port,
                             input sched_pkg::sched_entry_t exp_entry,
                             input logic [PIW-1:0] act_port,
                             input sched_pkg::sched_entry_t act_entry);
        checks++;
        if (exp_port !== act_port || exp_entry !== act_entry) begin
            errors++;
            $display("mismatch %s pop: expected %s, actual %s", name,
                     entry_text(exp_port, exp_entry), entry_text(act_port, act_entry));
        end
    endtask

    task automatic check_fetch(input string name, input logic [PIW-1:0] exp_port,
                               input sched_pkg::sched_entry_t exp_entry,
                               input logic [PIW-1:0] act_port,
                               input sched_pkg::sched_entry_t act_entry);
        checks++;
        if (exp_port !== act_port || exp_entry !== act_entry) begin
            errors++;
            $display("mismatch %s fetch: expected %s, actual %s", name,
                     entry_text(exp_port, exp_entry), entry_text(act_port, act_entry));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // New packets, pause bits and ready, then queue_valid from the counts
    task automatic apply_stimulus();
        int p;
        int t;
        if (int'($urandom_range(99)) < add_pct) begin
            p = int'($urandom_range(NP - 1));
            cnt[p][$urandom_range(Q - 1)]++;
        end
        if (pfc_pm == 0) begin
            pfc = '0;
            if (hold_tc >= 0) begin
                for (p = 0; p < NP; p++) begin
                    pfc[p][hold_tc] = 1'b1;
                end
            end
        end else if (int'($urandom_range(999)) < pfc_pm) begin
            p = int'($urandom_range(NP - 1));
            t = int'($urandom_range(TC - 1));
            pfc[p][t] = ~pfc[p][t];
        end
        for (p = 0; p < NP; p++) begin
            for (t = 0; t < TC; t++) begin
                for (int s = 0; s < SRC; s++) begin
                    queue_valid[p][t][s] = (cnt[p][t*SRC+s] > 0);
                end
            end
        end
        case (ready_mode)
            0:       fetch_ready = ($urandom_range(3) != 0);
            1:       fetch_ready = 1'b0;
            default: fetch_ready = 1'b1;
        endcase
    endtask

    // One clock edge of the reference model from this cycle's inputs
    task automatic step_model();
        int ep;
        int q;
        int found;
        ep    = (m_cur + 1) % NP;
        found = -1;
        // Only an empty slot takes a winner
        if (!m_full[ep]) begin
            for (int k = 0; k < Q; k++) begin
                q = (m_ptr[ep] + k) % Q;
                if (found < 0 && cnt[ep][q] > 0 && !m_pfc_q[ep][q/SRC] &&
                    !(m_pop_valid && m_pop_port == ep && m_pop_q == q)) begin
                    found = q;
                end
            end
        end
        if (m_full[m_cur] && fetch_ready) begin
            m_full[m_cur] = 1'b0;
        end
        if (found >= 0) begin
            m_full[ep]  = 1'b1;
            m_slot[ep]  = found;
            m_ptr[ep]   = (found + 1) % Q;
            m_pop_valid = 1'b1;
            m_pop_port  = ep;
            m_pop_q     = found;
        end else begin
            m_pop_valid = 1'b0;
        end
        m_cur   = ep;
        m_pfc_q = pfc;
    endtask

    task automatic compare_outputs();
        sched_pkg::sched_entry_t act;
        int q;
        check_flag({test_name, " pop_valid"}, m_pop_valid, pop_valid);
        act.tc  = pop_tc;
        act.src = pop_src;
        if (m_pop_valid && pop_valid) begin
            check_pop(test_name, PIW'(m_pop_port), to_entry(m_pop_q), pop_port, act);
        end
        if (pop_valid) begin
            pops++;
            q = int'(pop_tc) * SRC + int'(pop_src);
            check_flag({test_name, " popped queue holds packets"}, 1'b1,
                       cnt[int'(pop_port)][q] > 0);
            // Paused class must be gone from pops two cycles after pfc rises
            if (hold_tc >= 0 && hold_age >= 2) begin
                check_flag({test_name, " pop of paused class"}, 1'b0, int'(pop_tc) == hold_tc);
            end
        end
        check_flag({test_name, " fetch_valid"}, m_full[m_cur], fetch_valid);
        act.tc  = fetch_tc;
        act.src = fetch_src;
        if (m_full[m_cur] && fetch_valid) begin
            check_fetch(test_name, PIW'(m_cur), to_entry(m_slot[m_cur]), fetch_port, act);
        end
        // A held request must not change while the reader stalls
        if (ready_mode == 1 && fetch_valid) begin
            if (stall_seen[int'(fetch_port)]) begin
                check_fetch({test_name, " held"}, fetch_port, stall_entry[int'(fetch_port)],
                            fetch_port, act);
            end else begin
                stall_seen[int'(fetch_port)]  = 1'b1;
                stall_entry[int'(fetch_port)] = act;
            end
        end
    endtask

    // Sample just after the edge, then drive and advance the model
    task automatic run_cycle();
        @(posedge clk);
        #1;
        compare_outputs();
        if (dec_pend && cnt[dec_port][dec_q] > 0) begin
            cnt[dec_port][dec_q]--;
        end
        dec_pend = pop_valid;
        dec_port = int'(pop_port);
        dec_q    = int'(pop_tc) * SRC + int'(pop_src);
        apply_stimulus();
        if (fetch_valid && fetch_ready) begin
            accepts++;
        end
        step_model();
        if (hold_tc >= 0) begin
            hold_age++;
        end
    endtask

    function automatic bit drained();
        bit busy;
        busy = dec_pend || m_pop_valid;
        for (int p = 0; p < NP; p++) begin
            busy = busy || m_full[p];
            for (int q = 0; q < Q; q++) begin
                busy = busy || (cnt[p][q] > 0);
            end
        end
        return !busy;
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("test %s: %s, %0d errors", test_name,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    endtask

    // Test sequence, stops early when a wait runs out
    task automatic run_tests();
        // Idle after reset, then one packet per port and wait for the first pop
        begin_test("reset_first_pops");
        repeat (5) run_cycle();
        for (int p = 0; p < NP; p++) begin
            cnt[p][$urandom_range(Q - 1)] += 1;
        end
        n = 0;
        while (!pop_valid && n < 20) begin
            run_cycle();
            n++;
        end
        if (!pop_valid) begin
            $display("no pop within 20 cycles after the first packets arrived");
            hung = 1'b1;
            return;
        end
        repeat (3 * NP) run_cycle();
        end_test();

        begin_test("random_traffic");
        add_pct = 40;
        pfc_pm  = 10;
        repeat (400) run_cycle();
        end_test();

        // Reader stalls, then takes everything
        begin_test("backpressure");
        add_pct    = 50;
        ready_mode = 1;
        for (int p = 0; p < NP; p++) begin
            stall_seen[p] = 1'b0;
        end
        repeat (60) run_cycle();
        ready_mode = 2;
        repeat (4 * NP) run_cycle();
        ready_mode = 0;
        repeat (100) run_cycle();
        end_test();

        // One class paused on every port, then released
        begin_test("pause_burst");
        add_pct  = 40;
        pfc_pm   = 0;
        hold_age = 0;
        hold_tc  = int'($urandom_range(TC - 1));
        repeat (40) run_cycle();
        hold_tc = -1;
        repeat (40) run_cycle();
        end_test();

        begin_test("drain");
        add_pct    = 0;
        ready_mode = 2;
        n          = 0;
        while (!drained() && n < 3000) begin
            run_cycle();
            n++;
        end
        if (!drained()) begin
            $display("queues or slots still busy after %0d drain cycles", n);
            hung = 1'b1;
            return;
        end
        check_flag({test_name, " accepted fetches equal pops"}, 1'b1, accepts == pops);
        end_test();
    endtask

    initial begin
        void'($urandom(71961));
        rst_n       = 1'b0;
        queue_valid = '0;
        pfc         = '0;
        fetch_ready = 1'b0;
        m_pfc_q     = '0;
        m_cur       = 0;
        m_pop_valid = 1'b0;
        m_pop_port  = 0;
        m_pop_q     = 0;
        dec_pend    = 1'b0;
        dec_port    = 0;
        dec_q       = 0;
        add_pct     = 0;
        pfc_pm      = 0;
        ready_mode  = 0;
        hold_tc     = -1;
        hold_age    = 0;
        errors      = 0;
        checks      = 0;
        pops        = 0;
        accepts     = 0;
        hung        = 1'b0;
        for (int p = 0; p < NP; p++) begin
            m_ptr[p]      = 0;
            m_full[p]     = 1'b0;
            m_slot[p]     = 0;
            stall_seen[p] = 1'b0;
            for (int q = 0; q < Q; q++) begin
                cnt[p][q] = 0;
            end
        end

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        apply_stimulus();
        step_model();

        run_tests();

        $display("checks %0d, errors %0d, pops %0d, accepted fetches %0d",
                 checks, errors, pops, accepts);
        if (errors == 0 && !hung) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : sched_tb

// File: design/fetch_scheduler_top.sv
// Top level of the egress packet fetch scheduler
// Plain ports toward the queue manager, the transmit controller and the packet
// reader, with the decode, execute and result stages wired inside

`timescale 1ns/1ps

module fetch_scheduler_top #(
    parameter int NUM_PORTS = sched_pkg::DEF_NUM_PORTS,
    parameter int TC_COUNT  = sched_pkg::DEF_TC_COUNT,
    parameter int SRC_COUNT = sched_pkg::DEF_SRC_COUNT
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    // Queue occupancy from the queue manager
    input  logic [NUM_PORTS-1:0][TC_COUNT-1:0][SRC_COUNT-1:0] queue_valid,
    // Priority flow control from the transmit controller
    input  logic [NUM_PORTS-1:0][TC_COUNT-1:0]                pfc,
    // Fetch request to the packet reader
    output logic                                              fetch_valid,
    input  logic                                              fetch_ready,
    output logic [sched_pkg::PORT_IDX_W-1:0]                  fetch_port,
    output logic [sched_pkg::TC_IDX_W-1:0]                    fetch_tc,
    output logic [sched_pkg::SRC_IDX_W-1:0]                   fetch_src,
    // Pop to the queue manager
    output logic                                              pop_valid,
    output logic [sched_pkg::PORT_IDX_W-1:0]                  pop_port,
    output logic [sched_pkg::TC_IDX_W-1:0]                    pop_tc,
    output logic [sched_pkg::SRC_IDX_W-1:0]                   pop_src
);

    logic [sched_pkg::PORT_IDX_W-1:0] cur_port;
    logic [sched_pkg::PORT_IDX_W-1:0] elig_port;
    logic [TC_COUNT*SRC_COUNT-1:0]    elig;
    sched_pkg::sched_entry_t          pop_entry;
    sched_pkg::sched_entry_t          fetch_entry;

    // Pick path between execute and result
    sched_pick_if #(.NUM_PORTS(NUM_PORTS)) pick_if ();

    // Decode: rotation, pause and eligibility
    queue_eligibility #(
        .NUM_PORTS(NUM_PORTS),
        .TC_COUNT (TC_COUNT),
        .SRC_COUNT(SRC_COUNT)
    ) i_queue_eligibility (
        .clk        (clk),
        .rst_n      (rst_n),
        .queue_valid(queue_valid),
        .pfc        (pfc),
        .pop_valid  (pop_valid),
        .pop_port   (pop_port),
        .pop_entry  (pop_entry),
        .cur_port   (cur_port),
        .elig_port  (elig_port),
        .elig       (elig)
    );

    // Execute: round-robin pick
    rr_queue_picker #(
        .NUM_PORTS(NUM_PORTS),
        .TC_COUNT (TC_COUNT),
        .SRC_COUNT(SRC_COUNT)
    ) i_rr_queue_picker (
        .clk      (clk),
        .rst_n    (rst_n),
        .elig_port(elig_port),
        .elig     (elig),
        .pick     (pick_if.picker)
    );

    // Result: pending winners, pops and fetch requests
    port_slot_table #(
        .NUM_PORTS(NUM_PORTS)
    ) i_port_slot_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur_port   (cur_port),
        .pick       (pick_if.slots),
        .fetch_ready(fetch_ready),
        .fetch_valid(fetch_valid),
        .fetch_entry(fetch_entry),
        .pop_valid  (pop_valid),
        .pop_port   (pop_port),
        .pop_entry  (pop_entry)
    );

    // Request always names the port whose turn it is
    assign fetch_port = cur_port;
    assign fetch_tc   = fetch_entry.tc;
    assign fetch_src  = fetch_entry.src;
    assign pop_tc     = pop_entry.tc;
    assign pop_src    = pop_entry.src;

endmodule : fetch_scheduler_top

// File: design/port_slot_table.sv
// Result stage of the fetch scheduler
// Holds at most one pending winner per port, pops the queue when the winner is
// taken, and offers the slot of the current port to the packet reader

`timescale 1ns/1ps

module port_slot_table #(
    parameter int NUM_PORTS = sched_pkg::DEF_NUM_PORTS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [sched_pkg::PORT_IDX_W-1:0] cur_port,
    sched_pick_if.slots                      pick,
    input  logic                             fetch_ready,
    output logic                             fetch_valid,
    output sched_pkg::sched_entry_t          fetch_entry,
    output logic                             pop_valid,
    output logic [sched_pkg::PORT_IDX_W-1:0] pop_port,
    output sched_pkg::sched_entry_t          pop_entry
);

    localparam int PIW = sched_pkg::PORT_IDX_W;
    localparam int PW  = $clog2(NUM_PORTS);

    // Slot state per port
    logic [NUM_PORTS-1:0]    slot_full;
    sched_pkg::sched_entry_t slot_entry [NUM_PORTS];
    logic [PW-1:0]           cur_idx;
    logic                    fetch_done;

    assign cur_idx = cur_port[PW-1:0];

    // Picker may only fill an empty slot
    assign pick.slot_open = ~slot_full[pick.pick_port];

    // Request for the port whose turn it is
    assign fetch_valid = slot_full[cur_idx];
    assign fetch_entry = slot_entry[cur_idx];
    assign fetch_done  = fetch_valid & fetch_ready;

    // Full flags
    // Picked port is always cur_port + 1, so a fill and a drain never share a slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_full <= '0;
        end else begin
            if (fetch_done) begin
                slot_full[cur_idx] <= 1'b0;
            end
            if (pick.pick_valid) begin
                slot_full[pick.pick_port] <= 1'b1;
            end
        end
    end

    // Winner stays unchanged until the reader takes it
    always_ff @(posedge clk) begin
        if (pick.pick_valid) begin
            slot_entry[pick.pick_port] <= pick.pick_entry;
        end
    end

    // One-cycle pop to the queue manager for each stored pick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= pick.pick_valid;
        end
    end

    // Pop payload, held between pops
    always_ff @(posedge clk) begin
        if (pick.pick_valid) begin
            pop_port  <= PIW'(pick.pick_port);
            pop_entry <= pick.pick_entry;
        end
    end

endmodule : port_slot_table

// File: design/rr_queue_picker.sv
// Execute stage of the fetch scheduler
// Round-robin pick among the eligible queues of the scheduled port,
// with one pointer per port that moves past each winner

`timescale 1ns/1ps

module rr_queue_picker #(
    parameter int NUM_PORTS = sched_pkg::DEF_NUM_PORTS,
    parameter int TC_COUNT  = sched_pkg::DEF_TC_COUNT,
    parameter int SRC_COUNT = sched_pkg::DEF_SRC_COUNT
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [sched_pkg::PORT_IDX_W-1:0] elig_port,
    input  logic [TC_COUNT*SRC_COUNT-1:0]    elig,
    sched_pick_if.picker                     pick
);

    localparam int QUEUES = TC_COUNT * SRC_COUNT;
    localparam int QW     = (QUEUES > 1) ? $clog2(QUEUES) : 1;
    localparam int PW     = $clog2(NUM_PORTS);

    // Round-robin pointer per port, first flat index to try
    logic [QW-1:0] rr_ptr [NUM_PORTS];
    logic [QW-1:0] cur_ptr;
    logic [QW-1:0] win_idx;
    logic [QW-1:0] win_next;
    logic          any_elig;

    assign cur_ptr = rr_ptr[elig_port[PW-1:0]];

    // First eligible index at or after the pointer, wrapping around
    always_comb begin
        int idx;
        any_elig = 1'b0;
        win_idx  = cur_ptr;
        for (int k = 0; k < QUEUES; k++) begin
            idx = int'(cur_ptr) + k;
            if (idx >= QUEUES) begin
                idx = idx - QUEUES;
            end
            if (!any_elig && elig[idx]) begin
                any_elig = 1'b1;
                win_idx  = QW'(idx);
            end
        end
    end

    // Pointer moves to one past the winner
    always_comb begin
        if (win_idx == QW'(QUEUES - 1)) begin
            win_next = '0;
        end else begin
            win_next = win_idx + 1'b1;
        end
    end

    // Split the flat index into class and source
    always_comb begin
        pick.pick_entry = '0;
        for (int t = 0; t < TC_COUNT; t++) begin
            for (int s = 0; s < SRC_COUNT; s++) begin
                if (win_idx == QW'(t * SRC_COUNT + s)) begin
                    pick.pick_entry.tc  = sched_pkg::TC_IDX_W'(t);
                    pick.pick_entry.src = sched_pkg::SRC_IDX_W'(s);
                end
            end
        end
    end

    // Only pick into an empty slot
    assign pick.pick_port  = elig_port[PW-1:0];
    assign pick.pick_valid = any_elig & pick.slot_open;

    // Pointer holds while the slot is full or nothing is eligible
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                rr_ptr[p] <= '0;
            end
        end else if (pick.pick_valid) begin
            rr_ptr[pick.pick_port] <= win_next;
        end
    end

endmodule : rr_queue_picker

// File: design/queue_eligibility.sv
// Decode stage of the fetch scheduler
// Owns the port rotation and the registered pause bits, and builds the
// eligibility vector of the port scheduled next

`timescale 1ns/1ps

module queue_eligibility #(
    parameter int NUM_PORTS = sched_pkg::DEF_NUM_PORTS,
    parameter int TC_COUNT  = sched_pkg::DEF_TC_COUNT,
    parameter int SRC_COUNT = sched_pkg::DEF_SRC_COUNT
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [NUM_PORTS-1:0][TC_COUNT-1:0][SRC_COUNT-1:0] queue_valid,
    input  logic [NUM_PORTS-1:0][TC_COUNT-1:0]                pfc,
    input  logic                                              pop_valid,
    input  logic [sched_pkg::PORT_IDX_W-1:0]                  pop_port,
    input  sched_pkg::sched_entry_t                           pop_entry,
    output logic [sched_pkg::PORT_IDX_W-1:0]                  cur_port,
    output logic [sched_pkg::PORT_IDX_W-1:0]                  elig_port,
    output logic [TC_COUNT*SRC_COUNT-1:0]                     elig
);

    localparam int PIW    = sched_pkg::PORT_IDX_W;
    localparam int PW     = $clog2(NUM_PORTS);
    localparam int QUEUES = TC_COUNT * SRC_COUNT;

    // Registered pause bits, one per port and class
    logic [NUM_PORTS-1:0][TC_COUNT-1:0] pfc_q;
    // Per-queue masks for the port being scheduled
    logic [QUEUES-1:0]                  pause_mask;
    logic [QUEUES-1:0]                  pop_mask;
    logic [QUEUES-1:0]                  occupied;
    logic [PW-1:0]                      elig_idx;

    // Port rotation, next port wraps at NUM_PORTS
    always_comb begin
        if (cur_port == PIW'(NUM_PORTS - 1)) begin
            elig_port = '0;
        end else begin
            elig_port = cur_port + 1'b1;
        end
    end

    assign elig_idx = elig_port[PW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_port <= '0;
        end else begin
            cur_port <= elig_port;
        end
    end

    // Pause takes effect one cycle after pfc rises
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pfc_q <= '0;
        end else begin
            pfc_q <= pfc;
        end
    end

    // Occupancy of the scheduled port, flat order tc * SRC_COUNT + src
    assign occupied = queue_valid[elig_idx];

    // Expand class pause to every source of that class
    // Also mask a queue the queue manager has not yet updated after a pop
    always_comb begin
        pause_mask = '0;
        pop_mask   = '0;
        for (int t = 0; t < TC_COUNT; t++) begin
            for (int s = 0; s < SRC_COUNT; s++) begin
                pause_mask[t*SRC_COUNT+s] = pfc_q[elig_idx][t];
                if (pop_valid && (pop_port == elig_port) &&
                    (pop_entry.tc == sched_pkg::TC_IDX_W'(t)) &&
                    (pop_entry.src == sched_pkg::SRC_IDX_W'(s))) begin
                    pop_mask[t*SRC_COUNT+s] = 1'b1;
                end
            end
        end
    end

    assign elig = occupied & ~pause_mask & ~pop_mask;

endmodule : queue_eligibility

// File: design/sched_pick_if.sv
// Pick path between the round-robin picker and the per-port slot table
// The picker offers one winner per cycle, the slot table answers with slot_open

`timescale 1ns/1ps

interface sched_pick_if #(
    parameter int NUM_PORTS = sched_pkg::DEF_NUM_PORTS
);

    // Port index inside the design, sized to the port count
    localparam int PW = $clog2(NUM_PORTS);

    // Winner valid for the port being scheduled this cycle
    logic                     pick_valid;
    // Port being scheduled, driven every cycle
    logic [PW-1:0]            pick_port;
    // Class and source of the winning queue
    sched_pkg::sched_entry_t  pick_entry;
    // Slot of pick_port is empty
    logic                     slot_open;

    // Picker side
    modport picker (
        output pick_valid,
        output pick_port,
        output pick_entry,
        input  slot_open
    );

    // Slot table side
    modport slots (
        input  pick_valid,
        input  pick_port,
        input  pick_entry,
        output slot_open
    );

endinterface : sched_pick_if

// File: design/sched_pkg.sv
// Shared widths, default sizes and the queue entry type of the fetch scheduler
// Referenced by scoped name from the RTL stages, the top level and the testbench

package sched_pkg;

    // Index widths sized for the largest supported configuration
    // Up to 8 ports
    localparam int PORT_IDX_W = 3;
    // Up to 8 traffic classes per port
    localparam int TC_IDX_W   = 3;
    // Up to 8 source memory groups per class
    localparam int SRC_IDX_W  = 3;

    // Default build sizes
    // Top level and testbench both start from these
    localparam int DEF_NUM_PORTS = 4;
    localparam int DEF_TC_COUNT  = 8;
    localparam int DEF_SRC_COUNT = 4;

    // One queue within a port
    // Flat index inside the port is tc * SRC_COUNT + src
    typedef struct packed {
        logic [TC_IDX_W-1:0]  tc;
        logic [SRC_IDX_W-1:0] src;
    } sched_entry_t;

endpackage : sched_pkg
